// File: files.f
cache_pkg.sv
generic_bus_if.sv
l1_cache.sv
memory_arbiter.sv
main_memory.sv
caches_top.sv
tb_caches_top.sv

// File: tb_caches_top.sv
//////////////////////////////////////////////////
// self-checking testbench for the cache subsystem
// lfsr stimulus against a flat word memory model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_caches_top;
  import cache_pkg::*;

  // operation counts per phase
  localparam int N_RW = 40;
  localparam int N_HIT = 3;
  localparam int N_MMIO = 24;
  localparam int N_FLUSH = 3;
  localparam int N_IREAD = 64;
  localparam int N_MIX = 32;
  localparam int N_TAIL = 16;
  localparam int TOTAL_OPS = N_RW + N_HIT + N_MMIO + N_FLUSH + N_IREAD + 2 * N_MIX + N_TAIL;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_OPS * (MEM_LATENCY + 2);
  localparam time DRIVE_DELAY = 2;

  logic CLK;
  logic i_arst_n;
  word_t i_i_addr, i_i_wdata, o_i_rdata;
  logic i_i_ren, i_i_wen, o_i_busy, i_i_flush, o_i_flush_done;
  word_t i_d_addr, i_d_wdata, o_d_rdata;
  logic i_d_ren, i_d_wen, o_d_busy, i_d_flush, o_d_flush_done;

  // flat model since memory aliases modulo its depth
  word_t model_mem [MEM_WORDS];
  logic [31:0] lfsr_q = 32'h3608_154d;
  int cycle_cnt = 0;

  // pre-drawn stimulus for the concurrent phase
  word_t mix_d_addr [N_MIX];
  word_t mix_d_data [N_MIX];
  word_t mix_i_addr [N_MIX];

  caches_top DUT (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // run limit scaled by the amount of traffic
  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout, run went past %0d cycles without finishing",
                               TIMEOUT_CYCLES));
    end
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t: %s, got %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_flush(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t: %s, got %b, expected %b",
                               $time, what, got, exp));
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic word_t take_bits(input int n);
    word_t r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[WORD_W-2:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // one data side transfer where hit_exp checks the zero-wait hit
  task automatic data_access(input word_t addr, input logic wr, input word_t wdata,
                             input bit hit_exp);
    int widx;
    widx = addr[2 +: MEM_AW];
    @(posedge CLK);
    #DRIVE_DELAY;
    i_d_addr = addr;
    i_d_wdata = wdata;
    i_d_ren = ~wr;
    i_d_wen = wr;
    @(negedge CLK);
    if (hit_exp) begin
      check_flush(o_d_busy, 1'b0, "busy raised on a primed hit");
    end
    // hold the request until busy drops
    while (o_d_busy) begin
      @(negedge CLK);
    end
    if (wr) begin
      model_mem[widx] = wdata;
    end else begin
      check_word(o_d_rdata, model_mem[widx], $sformatf("data read of %h", addr));
    end
    @(posedge CLK);
    #DRIVE_DELAY;
    i_d_ren = 1'b0;
    i_d_wen = 1'b0;
  endtask

  // instruction side read checked against the model
  task automatic instr_read(input word_t addr);
    @(posedge CLK);
    #DRIVE_DELAY;
    i_i_addr = addr;
    i_i_ren = 1'b1;
    @(negedge CLK);
    while (o_i_busy) begin
      @(negedge CLK);
    end
    check_word(o_i_rdata, model_mem[addr[2 +: MEM_AW]], $sformatf("instr read of %h", addr));
    @(posedge CLK);
    #DRIVE_DELAY;
    i_i_ren = 1'b0;
  endtask

  // strobe a flush and expect exactly one done pulse
  task automatic flush_cache(input logic instr);
    @(posedge CLK);
    #DRIVE_DELAY;
    if (instr) begin
      i_i_flush = 1'b1;
    end else begin
      i_d_flush = 1'b1;
    end
    @(posedge CLK);
    #DRIVE_DELAY;
    i_i_flush = 1'b0;
    i_d_flush = 1'b0;
    @(negedge CLK);
    while (!(instr ? o_i_flush_done : o_d_flush_done)) begin
      @(negedge CLK);
    end
    repeat (4) begin
      @(negedge CLK);
      check_flush(instr ? o_i_flush_done : o_d_flush_done, 1'b0, "extra flush done pulse");
    end
  endtask

  initial begin
    word_t addr;
    word_t hi;
    word_t lo;
    logic wr;

    i_arst_n = 1'b0;
    i_i_addr = '0;
    i_i_wdata = '0;
    i_i_ren = 1'b0;
    i_i_wen = 1'b0;
    i_i_flush = 1'b0;
    i_d_addr = '0;
    i_d_wdata = '0;
    i_d_ren = 1'b0;
    i_d_wen = 1'b0;
    i_d_flush = 1'b0;
    for (int k = 0; k < MEM_WORDS; k++) begin
      model_mem[k] = '0;
    end
    repeat (10) @(posedge CLK);
    #DRIVE_DELAY;
    i_arst_n = 1'b1;
    @(negedge CLK);
    check_flush(o_d_flush_done, 1'b0, "flush done high after reset");
    check_flush(o_i_flush_done, 1'b0, "instr flush done high after reset");
    check_flush(o_d_busy, 1'b0, "data busy high after reset");
    check_flush(o_i_busy, 1'b0, "instr busy high after reset");

    // words 0..63 with four tags per index force dirty evictions
    for (int k = 0; k < N_RW; k++) begin
      wr = 1'(take_bits(1));
      addr = take_bits(6) << 2;
      data_access(addr, wr, take_bits(32), 1'b0);
    end

    // prime one line then write and read hits
    data_access(32'h0000_00c8, 1'b0, '0, 1'b0);
    data_access(32'h0000_00c8, 1'b1, take_bits(32), 1'b1);
    data_access(32'h0000_00c8, 1'b0, '0, 1'b1);

    // mmio with bits 9:8 set keeps words in 192..255
    for (int k = 0; k < N_MMIO; k++) begin
      wr = 1'(take_bits(1));
      hi = take_bits(22);
      lo = take_bits(6);
      addr = {hi[21:0], 2'b11, lo[5:0], 2'b00};
      data_access(addr, wr, take_bits(32), 1'b0);
    end

    // write back dirty lines then fetch them through the icache
    flush_cache(1'b0);
    for (int k = 0; k < N_IREAD; k++) begin
      instr_read(k * 4);
    end

    // dcache writes words 64..191 while icache reads flushed words
    for (int k = 0; k < N_MIX; k++) begin
      mix_d_addr[k] = (64 + take_bits(7)) * 4;
      mix_d_data[k] = take_bits(32);
      mix_i_addr[k] = take_bits(6) << 2;
    end
    fork
      begin
        for (int k = 0; k < N_MIX; k++) begin
          data_access(mix_d_addr[k], 1'b1, mix_d_data[k], 1'b0);
        end
      end
      begin
        for (int k = 0; k < N_MIX; k++) begin
          instr_read(mix_i_addr[k]);
        end
      end
    join

    // new data reaches the icache only after a flush
    flush_cache(1'b0);
    for (int k = 0; k < N_TAIL; k++) begin
      instr_read(mix_d_addr[k]);
    end

    // icache walk sees clean lines only
    flush_cache(1'b1);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: caches_top.sv
//////////////////////////////////////////////////
// cache subsystem top, two l1s, arbiter, memory
//////////////////////////////////////////////////
`timescale 1ns/1ps

module caches_top (
  input logic CLK,
  input logic i_arst_n,
  // instruction side
  input cache_pkg::word_t i_i_addr,
  input cache_pkg::word_t i_i_wdata,
  input logic i_i_ren,
  input logic i_i_wen,
  output cache_pkg::word_t o_i_rdata,
  output logic o_i_busy,
  input logic i_i_flush,
  output logic o_i_flush_done,
  // data side
  input cache_pkg::word_t i_d_addr,
  input cache_pkg::word_t i_d_wdata,
  input logic i_d_ren,
  input logic i_d_wen,
  output cache_pkg::word_t o_d_rdata,
  output logic o_d_busy,
  input logic i_d_flush,
  output logic o_d_flush_done
);

  // processor to l1
  generic_bus_if i_cpu_bus_if ();
  generic_bus_if d_cpu_bus_if ();
  // l1 to arbiter
  generic_bus_if i_l1_arb_bus_if ();
  generic_bus_if d_l1_arb_bus_if ();
  // arbiter to memory
  generic_bus_if arb_mem_bus_if ();

  assign i_cpu_bus_if.addr = i_i_addr;
  assign i_cpu_bus_if.wdata = i_i_wdata;
  assign i_cpu_bus_if.ren = i_i_ren;
  assign i_cpu_bus_if.wen = i_i_wen;
  assign o_i_rdata = i_cpu_bus_if.rdata;
  assign o_i_busy = i_cpu_bus_if.busy;

  assign d_cpu_bus_if.addr = i_d_addr;
  assign d_cpu_bus_if.wdata = i_d_wdata;
  assign d_cpu_bus_if.ren = i_d_ren;
  assign d_cpu_bus_if.wen = i_d_wen;
  assign o_d_rdata = d_cpu_bus_if.rdata;
  assign o_d_busy = d_cpu_bus_if.busy;

  l1_cache u_il1 (
    .CLK(CLK),
    .i_arst_n(i_arst_n),
    .i_flush(i_i_flush),
    .o_flush_done(o_i_flush_done),
    .proc(i_cpu_bus_if.slave),
    .mem(i_l1_arb_bus_if.master)
  );

  l1_cache u_dl1 (
    .CLK(CLK),
    .i_arst_n(i_arst_n),
    .i_flush(i_d_flush),
    .o_flush_done(o_d_flush_done),
    .proc(d_cpu_bus_if.slave),
    .mem(d_l1_arb_bus_if.master)
  );

  memory_arbiter u_arb (
    .CLK(CLK),
    .i_arst_n(i_arst_n),
    .icache(i_l1_arb_bus_if.slave),
    .dcache(d_l1_arb_bus_if.slave),
    .mem(arb_mem_bus_if.master)
  );

  main_memory u_mem (
    .CLK(CLK),
    .i_arst_n(i_arst_n),
    .bus(arb_mem_bus_if.slave)
  );

endmodule

// File: main_memory.sv
//////////////////////////////////////////////////
// word ram with fixed busy latency
//////////////////////////////////////////////////
`timescale 1ns/1ps

module main_memory (
  input logic CLK,
  input logic i_arst_n,
  generic_bus_if.slave bus
);
  import cache_pkg::*;

  word_t ram_q [MEM_WORDS];
  logic [LAT_W-1:0] wait_q;
  logic req;
  logic done;
  logic [MEM_AW-1:0] widx;

  assign req = bus.ren | bus.wen;
  // only low word address bits decoded
  assign widx = bus.addr.word[2 +: MEM_AW];
  // completes after MEM_LATENCY busy cycles
  assign done = req && (wait_q == LAT_W'(MEM_LATENCY));
  assign bus.busy = req & ~done;
  assign bus.rdata = ram_q[widx];

  always_ff @(posedge CLK or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wait_q <= '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        ram_q[i] <= '0;
      end
    end else begin
      // restart count for the next request
      if (done || !req) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
      // write lands on the completing cycle
      if (done && bus.wen) begin
        ram_q[widx] <= bus.wdata;
      end
    end
  end

endmodule

// File: memory_arbiter.sv
//////////////////////////////////////////////////
// two to one arbiter, icache and dcache misses
//////////////////////////////////////////////////
`timescale 1ns/1ps

module memory_arbiter (
  input logic CLK,
  input logic i_arst_n,
  generic_bus_if.slave icache,
  generic_bus_if.slave dcache,
  generic_bus_if.master mem
);

  logic grant_held_q;
  logic grant_d_q;
  logic sel_valid;
  logic sel_d;
  logic i_req;
  logic d_req;

  assign i_req = icache.ren | icache.wen;
  assign d_req = dcache.ren | dcache.wen;

  // held grant wins, else data side first
  always_comb begin
    if (grant_held_q) begin
      sel_valid = 1'b1;
      sel_d = grant_d_q;
    end else begin
      sel_valid = i_req | d_req;
      sel_d = d_req;
    end
  end

  // forward granted side, no added cycle
  always_comb begin
    mem.addr = sel_d ? dcache.addr : icache.addr;
    mem.wdata = sel_d ? dcache.wdata : icache.wdata;
    mem.ren = sel_valid & (sel_d ? dcache.ren : icache.ren);
    mem.wen = sel_valid & (sel_d ? dcache.wen : icache.wen);
  end

  assign dcache.rdata = mem.rdata;
  assign icache.rdata = mem.rdata;
  // losing side stalls while it requests
  assign dcache.busy = (sel_valid && sel_d) ? mem.busy : d_req;
  assign icache.busy = (sel_valid && !sel_d) ? mem.busy : i_req;

  // keep grant until the transfer completes
  always_ff @(posedge CLK or negedge i_arst_n) begin
    if (!i_arst_n) begin
      grant_held_q <= 1'b0;
      grant_d_q <= 1'b0;
    end else begin
      grant_held_q <= sel_valid & mem.busy;
      grant_d_q <= sel_d;
    end
  end

endmodule

// File: l1_cache.sv
//////////////////////////////////////////////////
// direct mapped write-back l1 cache
// mmio bypass and full flush walk
//////////////////////////////////////////////////
`timescale 1ns/1ps

module l1_cache (
  input logic CLK,
  input logic i_arst_n,
  input logic i_flush,
  output logic o_flush_done,
  generic_bus_if.slave proc,
  generic_bus_if.master mem
);
  import cache_pkg::*;

  // line storage
  word_t data_q [L1_LINES];
  logic [TAG_W-1:0] tag_q [L1_LINES];
  logic [L1_LINES-1:0] valid_q;
  logic [L1_LINES-1:0] dirty_q;

  // control
  logic [2:0] state_q;
  logic [INDEX_W-1:0] flush_idx_q;
  logic flush_done_q;

  logic proc_req;
  logic bypass;
  logic hit;
  logic wr_hit;
  logic mem_done;
  logic [INDEX_W-1:0] idx;
  logic [INDEX_W-1:0] wb_idx;
  logic wb_needed;
  addr_u wb_addr;

  assign idx = proc.addr.f.index;
  assign proc_req = proc.ren | proc.wen;
  // mmio range never allocates
  assign bypass = proc.addr.word >= NONCACHE_START_ADDR;
  assign hit = valid_q[idx] && (tag_q[idx] == proc.addr.f.tag) && !bypass;
  assign wr_hit = (state_q == L1_IDLE) && proc.wen && hit && !i_flush;
  assign mem_done = (mem.ren | mem.wen) & ~mem.busy;

  // victim line, flush walk or current miss
  assign wb_idx = (state_q == L1_FLUSH) ? flush_idx_q : idx;
  assign wb_needed = valid_q[wb_idx] & dirty_q[wb_idx];

  // rebuild victim address from stored tag
  always_comb begin
    wb_addr.f.tag = tag_q[wb_idx];
    wb_addr.f.index = wb_idx;
    wb_addr.f.offset = 2'b00;
  end

  // memory side request
  always_comb begin
    mem.addr = proc.addr;
    mem.wdata = data_q[wb_idx];
    mem.ren = 1'b0;
    mem.wen = 1'b0;
    case (state_q)
      L1_WB: begin
        mem.addr = wb_addr;
        mem.wen = 1'b1;
      end
      L1_FLUSH: begin
        mem.addr = wb_addr;
        // clean or invalid lines skip the bus
        mem.wen = wb_needed;
      end
      L1_FILL: begin
        mem.ren = 1'b1;
      end
      L1_BYPASS: begin
        // pass the processor request straight through
        mem.wdata = proc.wdata;
        mem.ren = proc.ren;
        mem.wen = proc.wen;
      end
      default: begin
        mem.ren = 1'b0;
      end
    endcase
  end

  // processor side response
  always_comb begin
    proc.rdata = data_q[idx];
    proc.busy = proc_req;
    if (state_q == L1_IDLE) begin
      // hit completes in the request cycle
      proc.busy = proc_req & ~hit;
    end else if (state_q == L1_BYPASS) begin
      proc.rdata = mem.rdata;
      proc.busy = mem.busy;
    end
  end

  // fsm, valid and dirty bits
  always_ff @(posedge CLK or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= L1_IDLE;
      valid_q <= '0;
      dirty_q <= '0;
      flush_idx_q <= '0;
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= 1'b0;
      case (state_q)
        L1_IDLE: begin
          if (i_flush) begin
            state_q <= L1_FLUSH;
            flush_idx_q <= '0;
          end else if (wr_hit) begin
            dirty_q[idx] <= 1'b1;
          end else if (proc_req && !hit) begin
            if (bypass) begin
              state_q <= L1_BYPASS;
            end else if (wb_needed) begin
              state_q <= L1_WB;
            end else begin
              state_q <= L1_FILL;
            end
          end
        end
        L1_WB: begin
          if (mem_done) begin
            dirty_q[idx] <= 1'b0;
            state_q <= L1_FILL;
          end
        end
        L1_FILL: begin
          // back to idle, request then hits
          if (mem_done) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
            state_q <= L1_IDLE;
          end
        end
        L1_BYPASS: begin
          if (mem_done) begin
            state_q <= L1_IDLE;
          end
        end
        L1_FLUSH: begin
          // step once the line is clean
          if (!wb_needed || mem_done) begin
            dirty_q[flush_idx_q] <= 1'b0;
            flush_idx_q <= flush_idx_q + 1'b1;
            if (&flush_idx_q) begin
              // last line done, drop everything
              valid_q <= '0;
              dirty_q <= '0;
              flush_done_q <= 1'b1;
              state_q <= L1_IDLE;
            end
          end
        end
        default: begin
          state_q <= L1_IDLE;
        end
      endcase
    end
  end

  // data and tag arrays
  always_ff @(posedge CLK) begin
    if (wr_hit) begin
      data_q[idx] <= proc.wdata;
    end else if (state_q == L1_FILL && mem_done) begin
      data_q[idx] <= mem.rdata;
      tag_q[idx] <= proc.addr.f.tag;
    end
  end

  assign o_flush_done = flush_done_q;

endmodule

// File: generic_bus_if.sv
//////////////////////////////////////////////////
// generic memory bus, busy based handshake
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface generic_bus_if;
  import cache_pkg::*;

  // request side
  addr_u addr;
  word_t wdata;
  logic ren;
  logic wen;

  // response side
  word_t rdata;
  // high while a request is pending
  logic busy;

  // requester, held stable while busy
  modport master (
    output addr, wdata, ren, wen,
    input rdata, busy
  );

  // responder
  modport slave (
    input addr, wdata, ren, wen,
    output rdata, busy
  );

endinterface

// File: cache_pkg.sv
//////////////////////////////////////////////////
// cache subsystem shared constants and types
// bus widths, l1 geometry, memory timing
//////////////////////////////////////////////////
package cache_pkg;

  // data and address width
  localparam int WORD_W = 32;

  // l1 geometry, one word per line
  localparam int L1_LINES = 16;
  localparam int INDEX_W = 4;
  // tag, index, then 2 byte offset bits
  localparam int TAG_W = WORD_W - INDEX_W - 2;

  // main memory depth, low word bits only
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW = $clog2(MEM_WORDS);
  // busy cycles before the completing cycle
  localparam int MEM_LATENCY = 2;
  localparam int LAT_W = $clog2(MEM_LATENCY + 1);

  // mmio region, bypasses both l1s
  localparam logic [WORD_W-1:0] NONCACHE_START_ADDR = 32'h0000_0300;

  // l1 fsm state codes
  localparam logic [2:0] L1_IDLE = 3'd0;
  localparam logic [2:0] L1_WB = 3'd1;
  localparam logic [2:0] L1_FILL = 3'd2;
  localparam logic [2:0] L1_BYPASS = 3'd3;
  localparam logic [2:0] L1_FLUSH = 3'd4;

  typedef logic [WORD_W-1:0] word_t;

  // same address word, flat or split for lookup
  typedef union packed {
    word_t word;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [INDEX_W-1:0] index;
      logic [1:0] offset;
    } f;
  } addr_u;

endpackage
